/* filelist.f */
hdl/busSizePkg.sv
hdl/sizingIf.sv
hdl/cycleDecode.sv
hdl/sizingEngine.sv
hdl/laneSteer.sv
hdl/busSizer.sv
tb/clockGen.sv
tb/busSizerCheck.sv
tb/busSizerTb.sv

/* hdl/busSizePkg.sv */
/* Types shared by the three bridge stages. Byte 0 sits in bits 31:24.
   Only 32-bit and 16-bit port answers are encoded. */
`default_nettype none

package busSizePkg;

    typedef logic [7:0]  laneData;   // One byte lane
    typedef logic [31:0] busData;    // Byte 0 is the most significant
    typedef logic [1:0]  xferSize;   // SIZ1 SIZ0
    typedef logic [1:0]  xferAddr;   // A1 A0
    typedef logic [1:0]  xferType;   // TT1 TT0
    typedef logic [1:0]  dsackCode;  // Active low port acknowledge

    // SIZ encodings
    localparam xferSize sizeLong = 2'b00;
    localparam xferSize sizeByte = 2'b01;
    localparam xferSize sizeWord = 2'b10;
    localparam xferSize sizeLine = 2'b11;

    localparam xferType typeLine = 2'b01;    // Line burst access

    // DSACK answers
    localparam dsackCode ack32   = 2'b00;
    localparam dsackCode ack16   = 2'b01;
    localparam dsackCode ackNone = 2'b11;

    typedef enum logic [3:0] {
        laneIdle,
        laneLongHi,      // Long word or high half on a 16-bit port
        laneLongLo,      // Low half on a 16-bit port
        laneWord0,
        laneWord2,
        laneByte0,
        laneByte1,
        laneByte2,
        laneByte3
    } laneMode;

    typedef enum logic [2:0] {
        stIdle,
        stPortStart,     // nTS low toward the port
        stWaitAck,
        stSecondStart,   // nTS for the low half
        stSecondWait
    } engineState;

endpackage

`default_nettype wire

/* hdl/busSizer.sv */
/* Dynamic bus sizing bridge for a 68040 style local bus. Ports answer as 32 or 16 bit.
   Data pins are split into in and out buses and all strobes leave on the rising BCLK edge. */
`default_nettype none

module busSizer #(
    parameter int BurstBeats = 4                 // Beats per line transfer
) (
    input  wire                       BCLK,
    input  wire                       nRESET,
    // CPU side
    input  wire                       nTS_CPU,
    input  wire                       RnW,
    input  wire busSizePkg::xferSize  SIZ,
    input  wire busSizePkg::xferAddr  A,
    input  wire busSizePkg::xferType  TT,
    input  wire                       nTBI,
    output logic                      nTA,
    input  wire busSizePkg::busData   cpuDataIn,
    output busSizePkg::busData        cpuDataOut,
    // Port side
    input  wire busSizePkg::dsackCode DSACK,
    output logic                      nTS,
    output busSizePkg::xferSize       portSiz,
    output busSizePkg::xferAddr       portA,
    input  wire busSizePkg::busData   portDataIn,
    output busSizePkg::busData        portDataOut,
    output logic                      portDrive
);

    xferIf xferBus ();     // Decode to engine
    laneIf laneBus ();     // Engine to steering

    //////////////////////////////
    // Stages
    //////////////////////////////

    cycleDecode decode_i (
        .BCLK    (BCLK),
        .nRESET  (nRESET),
        .nTS_CPU (nTS_CPU),
        .RnW     (RnW),
        .SIZ     (SIZ),
        .A       (A),
        .TT      (TT),
        .xfer    (xferBus.source)
    );

    sizingEngine #(
        .BurstBeats (BurstBeats)
    ) engine_i (
        .BCLK    (BCLK),
        .nRESET  (nRESET),
        .DSACK   (DSACK),
        .nTBI    (nTBI),
        .nTS     (nTS),
        .nTA     (nTA),
        .portSiz (portSiz),
        .portA   (portA),
        .xfer    (xferBus.sink),
        .lanes   (laneBus.source)
    );

    laneSteer steer_i (
        .BCLK        (BCLK),
        .nRESET      (nRESET),
        .cpuDataIn   (cpuDataIn),
        .portDataIn  (portDataIn),
        .cpuDataOut  (cpuDataOut),
        .portDataOut (portDataOut),
        .portDrive   (portDrive),
        .lanes       (laneBus.sink)
    );

endmodule

`default_nettype wire

/* hdl/cycleDecode.sv */
/* Samples the CPU transfer start while the engine is idle.
   Word and long addresses are forced aligned since misaligned words are not supported. */
`default_nettype none

module cycleDecode (
    input  wire                      BCLK,
    input  wire                      nRESET,
    input  wire                      nTS_CPU,
    input  wire                      RnW,
    input  wire busSizePkg::xferSize SIZ,
    input  wire busSizePkg::xferAddr A,
    input  wire busSizePkg::xferType TT,
    xferIf.source                    xfer
);
    import busSizePkg::*;

    logic take;      // Accept this transfer start
    logic isLine;

    // Ignore nTS_CPU until the engine has taken the last start
    assign take   = !nTS_CPU && !xfer.busy && !xfer.start;
    assign isLine = (SIZ == sizeLine);

    //////////////////////////////
    // Start strobe
    //////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            xfer.start <= 1'b0;
        end else begin
            xfer.start <= take;           // Single pulse per transfer
        end
    end

    //////////////////////////////
    // Descriptor capture
    //////////////////////////////

    always_ff @(posedge BCLK) begin
        if (take) begin
            xfer.size  <= isLine ? sizeLong : SIZ;      // One long shape for the engine
            xfer.write <= !RnW;
            xfer.burst <= isLine && (TT == typeLine);
            case (SIZ)
                sizeByte: begin
                    xfer.addr <= A;                     // Any byte lane
                end
                sizeWord: begin
                    xfer.addr <= {A[1], 1'b0};          // Word 0 or word 2
                end
                default: begin
                    xfer.addr <= 2'b00;                 // Long and line start at lane 0
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/laneSteer.sv */
/* Byte lane steering between CPU and port. Write routing is combinational.
   Read bytes are latched only for the lanes the mode selects. */
`default_nettype none

module laneSteer (
    input  wire                     BCLK,
    input  wire                     nRESET,
    input  wire busSizePkg::busData cpuDataIn,
    input  wire busSizePkg::busData portDataIn,
    output busSizePkg::busData      cpuDataOut,
    output busSizePkg::busData      portDataOut,
    output logic                    portDrive,
    laneIf.sink                     lanes
);
    import busSizePkg::*;

    laneData    cpuByte  [4];
    laneData    portByte [4];
    logic [3:0] readMask;     // Bit i enables CPU byte i
    logic       shiftDown;    // Narrow data for bytes 2 and 3 arrives on lanes 0 and 1

    // Split both buses into lanes with byte 0 on top
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cpuByte[i]  = cpuDataIn[31 - 8*i -: 8];
            portByte[i] = portDataIn[31 - 8*i -: 8];
        end
    end

    //////////////////////////////
    // Write path
    //////////////////////////////

    always_comb begin
        portDataOut = cpuDataIn;                             // Lanes pass through by default
        case (lanes.mode)
            laneLongLo, laneWord2: begin
                portDataOut[31:16] = {cpuByte[2], cpuByte[3]};   // Low half also on lanes 0 and 1
            end
            laneByte2: begin
                portDataOut[31:24] = cpuByte[2];
            end
            laneByte3: begin
                portDataOut[23:16] = cpuByte[3];
            end
            default: begin
                portDataOut = cpuDataIn;
            end
        endcase
    end

    assign portDrive = lanes.drive;

    //////////////////////////////
    // Read path
    //////////////////////////////

    always_comb begin
        shiftDown = !lanes.portWide || (lanes.mode == laneLongLo);
        case (lanes.mode)
            laneLongHi: readMask = lanes.portWide ? 4'b1111 : 4'b0011;
            laneLongLo: readMask = 4'b1100;
            laneWord0:  readMask = 4'b0011;
            laneWord2:  readMask = 4'b1100;
            laneByte0:  readMask = 4'b0001;
            laneByte1:  readMask = 4'b0010;
            laneByte2:  readMask = 4'b0100;
            laneByte3:  readMask = 4'b1000;
            default:    readMask = 4'b0000;
        endcase
    end

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cpuDataOut <= '0;
        end else if (lanes.capture) begin
            for (int i = 0; i < 4; i++) begin
                if (readMask[i]) begin
                    // Lanes 0 and 1 feed bytes 2 and 3 on a narrow port
                    cpuDataOut[31 - 8*i -: 8] <= (shiftDown && i >= 2) ? portByte[i % 2]
                                                                       : portByte[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sizingEngine.sv */
/* Port cycle sequencer. A 16-bit answer to a long word or line triggers one more
   port cycle for the low half. Byte-port answers are not supported. */
`default_nettype none

module sizingEngine #(
    parameter int BurstBeats = 4
) (
    input  wire                       BCLK,
    input  wire                       nRESET,
    input  wire busSizePkg::dsackCode DSACK,
    input  wire                       nTBI,
    output logic                      nTS,
    output logic                      nTA,
    output busSizePkg::xferSize       portSiz,
    output busSizePkg::xferAddr       portA,
    xferIf.sink                       xfer,
    laneIf.source                     lanes
);
    import busSizePkg::*;

    localparam int CountW = $clog2(BurstBeats) + 1;

    engineState        state;
    logic [CountW-1:0] beatCount;   // Line beats already acknowledged
    logic              ackSeen;     // DSACK sampled on this edge
    logic              narrowAck;
    logic              splitLong;   // 16-bit answer to the high half
    logic              lastBeat;
    logic              firstPort;   // Open the first port cycle
    logic              endCycle;

    //////////////////////////////
    // Acknowledge decode
    //////////////////////////////

    assign ackSeen   = (state == stWaitAck || state == stSecondWait) && (DSACK != ackNone);
    assign narrowAck = (DSACK == ack16);
    assign splitLong = (state == stWaitAck) && ackSeen && narrowAck && (xfer.size == sizeLong);
    assign lastBeat  = !xfer.burst || !nTBI || (beatCount == CountW'(BurstBeats - 1));
    assign firstPort = (state == stIdle) && xfer.start;
    assign endCycle  = ackSeen && !splitLong && ((state == stSecondWait) || lastBeat);

    assign xfer.busy = (state != stIdle);      // Falls on the final-beat edge

    //////////////////////////////
    // Port cycle sequencing
    //////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state     <= stIdle;
            nTS       <= 1'b1;
            nTA       <= 1'b1;
            beatCount <= '0;
        end else begin
            nTS <= !(firstPort || splitLong);   // One cycle per port start
            nTA <= !(ackSeen && !splitLong);    // One cycle per CPU beat
            case (state)
                stIdle: begin
                    if (xfer.start) begin
                        state <= stPortStart;
                    end
                end
                stPortStart: begin
                    state <= stWaitAck;           // Port cannot answer yet
                end
                stWaitAck: begin
                    if (splitLong) begin
                        state <= stSecondStart;
                    end else if (endCycle) begin
                        state <= stIdle;
                    end
                end
                stSecondStart: begin
                    state <= stSecondWait;
                end
                stSecondWait: begin
                    if (ackSeen) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase

            // Burst beat counter
            if (firstPort) begin
                beatCount <= '0;
            end else if (ackSeen && !splitLong && !endCycle) begin
                beatCount <= beatCount + 1'b1;
            end
        end
    end

    // Port size and address, held until the next port start
    always_ff @(posedge BCLK) begin
        if (firstPort) begin
            portSiz <= xfer.burst ? sizeLine : xfer.size;
            portA   <= xfer.addr;
        end else if (splitLong) begin
            portSiz <= sizeWord;                // Low half as a word at 2
            portA   <= 2'b10;
        end
    end

    //////////////////////////////
    // Lane mode
    //////////////////////////////

    always_comb begin
        lanes.mode = laneIdle;
        case (state)
            stIdle: begin
                lanes.mode = laneIdle;
            end
            stSecondStart, stSecondWait: begin
                lanes.mode = laneLongLo;
            end
            default: begin
                case (xfer.size)
                    sizeWord: lanes.mode = xfer.addr[1] ? laneWord2 : laneWord0;
                    sizeByte: begin
                        case (xfer.addr)
                            2'b00:   lanes.mode = laneByte0;
                            2'b01:   lanes.mode = laneByte1;
                            2'b10:   lanes.mode = laneByte2;
                            default: lanes.mode = laneByte3;
                        endcase
                    end
                    default: lanes.mode = laneLongHi;
                endcase
            end
        endcase
    end

    assign lanes.capture  = ackSeen;                     // Latch lands on the ack edge
    assign lanes.portWide = (DSACK == ack32);
    assign lanes.drive    = xfer.busy && xfer.write;

endmodule

`default_nettype wire

/* hdl/sizingIf.sv */
/* Handshakes between the bridge stages. start only pulses while busy is low
   and the descriptor holds until busy falls. */
`default_nettype none

// Captured CPU transfer, decode to execute
interface xferIf;
    import busSizePkg::*;

    logic    start;      // One cycle pulse
    xferSize size;       // A line arrives folded into long
    xferAddr addr;
    logic    write;
    logic    burst;      // Line burst qualified by TT
    logic    busy;       // Engine owns the descriptor

    modport source (output start, size, addr, write, burst, input busy);
    modport sink (input start, size, addr, write, burst, output busy);
endinterface

// Lane control, execute to result
interface laneIf;
    import busSizePkg::*;

    laneMode mode;
    logic    capture;    // High in the cycle before an ack edge
    logic    portWide;   // Port answered as 32-bit
    logic    drive;      // Write data toward the port

    modport source (output mode, capture, portWide, drive);
    modport sink (input mode, capture, portWide, drive);
endinterface

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the bus sizing testbench with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module busSizerTb \
    -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation did not complete, see build.log and sim.log"
grep -q "Result: FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No passing result in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

/* tb/busSizerCheck.sv */
/* Watches the bridge from the CPU side. The shadow memory follows CPU writes at nTA.
   Line writes are not expected. Transfer counts are checked when the next one starts. */
`default_nettype none

module busSizerCheck #(
    parameter int BurstBeats = 4
) (
    input  wire                       BCLK,
    input  wire                       nRESET,
    input  wire                       nTS_CPU,
    input  wire                       RnW,
    input  wire busSizePkg::xferSize  SIZ,
    input  wire                       nTBI,
    input  wire busSizePkg::busData   cpuDataIn,
    input  wire [5:0]                 cpuAddr,     // Full CPU byte address
    input  wire                       portWide,
    input  wire                       done,
    input  wire                       nTA,
    input  wire                       nTS,
    input  wire busSizePkg::xferSize  portSiz,
    input  wire busSizePkg::xferAddr  portA,
    input  wire                       portDrive,
    input  wire busSizePkg::busData   cpuDataOut,
    output int                        errors,
    output int                        checks
);
    timeunit 1ns;
    timeprecision 100ps;
    import busSizePkg::*;

    logic [7:0] shadow [64];
    logic       started;          // First transfer seen
    logic       pending;          // A transfer still to be closed
    int         ntaCnt;
    int         ntsCnt;
    xferSize    tSiz;             // Descriptor latched at transfer start
    logic [5:0] tAddr;
    logic       tWr;
    logic       tWide;
    logic       tTbi;

    function automatic logic [7:0] fillByte(input logic [5:0] a);
        return 8'(a * 8'd29 + 8'h5A);    // Odd step, so every byte differs
    endfunction

    // Bit i enables CPU byte i, byte 0 in bits 31:24
    function automatic logic [3:0] laneMask(input xferSize siz, input logic [5:0] a);
        case (siz)
            sizeByte: return 4'b0001 << a[1:0];
            sizeWord: return a[1] ? 4'b1100 : 4'b0011;
            default:  return 4'b1111;
        endcase
    endfunction

    // Reference for read data from the shadow memory
    function automatic busData expectRead(input xferSize siz, input logic [5:0] a, input int beat);
        busData     v;
        logic [3:0] m;
        logic [3:0] lw;
        v  = '0;
        m  = laneMask(siz, a);
        lw = a[5:2] + 4'(beat);
        for (int i = 0; i < 4; i++) begin
            if (m[i]) v[31 - 8*i -: 8] = shadow[{lw, 2'(i)}];
        end
        return v;
    endfunction

    function automatic busData expandMask(input logic [3:0] m);
        busData v;
        for (int i = 0; i < 4; i++) v[31 - 8*i -: 8] = {8{m[i]}};
        return v;
    endfunction

    function automatic int expNta();
        return (tSiz == sizeLine && tWide && tTbi) ? BurstBeats : 1;
    endfunction

    task automatic valueErr(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic closeXfer();
        int wantNts;
        wantNts = (!tWide && (tSiz == sizeLong || tSiz == sizeLine)) ? 2 : 1;
        if (ntaCnt != expNta()) begin
            $display("Transfer at %0t ended with %0d nTA pulses instead of %0d",
                     $time, ntaCnt, expNta());
            errors++;
        end
        if (ntsCnt != wantNts) begin
            $display("Transfer at %0t issued %0d port starts instead of %0d",
                     $time, ntsCnt, wantNts);
            errors++;
        end
        checks += 2;
        pending = 1'b0;
    endtask

    // One acknowledged CPU beat
    task automatic beatDone();
        busData     exp;
        busData     bm;
        logic [3:0] m;
        m = laneMask(tSiz, tAddr);
        if (tWr) begin
            for (int i = 0; i < 4; i++) begin
                if (m[i]) shadow[{tAddr[5:2], 2'(i)}] = cpuDataIn[31 - 8*i -: 8];
            end
        end else begin
            exp = expectRead(tSiz, tAddr, ntaCnt - 1);
            bm  = expandMask(m);
            if ((cpuDataOut & bm) !== exp) valueErr("cpuDataOut", exp, cpuDataOut & bm);
            checks++;
        end
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        started = 1'b0;
        pending = 1'b0;
        ntaCnt  = 0;
        ntsCnt  = 0;
        for (int a = 0; a < 64; a++) shadow[a] = fillByte(6'(a));
    end

    //////////////////////////////
    // Sampling on each edge
    //////////////////////////////

    always @(posedge BCLK) begin
        if (nRESET) begin
            if (!started) begin                             // Idle outputs before any start
                if (nTS !== 1'b1) valueErr("nTS", 1, nTS);
                if (nTA !== 1'b1) valueErr("nTA", 1, nTA);
                if (portDrive !== 1'b0) valueErr("portDrive", 0, portDrive);
                if (cpuDataOut !== '0) valueErr("cpuDataOut", 0, cpuDataOut);
                checks++;
            end
            if (nTS_CPU === 1'b0) begin
                if (pending) closeXfer();
                tSiz    = SIZ;
                tAddr   = cpuAddr;
                tWr     = !RnW;
                tWide   = portWide;
                tTbi    = nTBI;
                ntaCnt  = 0;
                ntsCnt  = 0;
                started = 1'b1;
                pending = 1'b1;
            end
            if (nTS === 1'b0) begin
                ntsCnt++;
                if (ntsCnt == 1) begin
                    if (portSiz !== tSiz) valueErr("portSiz", tSiz, portSiz);
                    // Aligned transfers open the port at their own address
                    if (portA !== tAddr[1:0]) valueErr("portA", tAddr[1:0], portA);
                end else begin
                    if (portA !== 2'b10) valueErr("portA", 2'b10, portA);   // Low half
                    if (portSiz !== sizeWord) valueErr("portSiz", sizeWord, portSiz);
                end
                if (portDrive !== tWr) valueErr("portDrive", tWr, portDrive);
                checks++;
            end
            if (nTA === 1'b0) begin
                ntaCnt++;
                if (!pending || ntaCnt > expNta()) begin
                    $display("Unexpected nTA at %0t outside a transfer", $time);
                    errors++;
                end else begin
                    beatDone();
                end
            end
            if (done && pending) closeXfer();
        end
    end

endmodule

`default_nettype wire

/* tb/busSizerTb.sv */
/* Plays the CPU and a 64-byte port of selectable width. Line transfers are reads only
   and start on a 16-byte boundary. Waits and random transfers come from a Galois LFSR. */
`default_nettype none

module busSizerTb;
    timeunit 1ns;
    timeprecision 100ps;
    import busSizePkg::*;

    localparam int Beats       = 4;
    localparam int NumRandom   = 200;
    localparam int NumDirected = 31;                     // Long, word, byte and line cases
    localparam int NumXfers    = NumDirected + NumRandom;
    localparam int TimeoutNs   = NumXfers * 40 * 10;

    logic       BCLK, nRESET, nTS_CPU, RnW, nTBI, nTA, nTS, portDrive;
    xferSize    SIZ, portSiz;
    xferAddr    A, portA;
    xferType    TT;
    dsackCode   DSACK;
    busData     cpuDataIn, cpuDataOut, portDataIn, portDataOut;
    logic [7:0] portMem [64];
    logic       portWide;          // Port answers as 32-bit
    logic [5:0] cpuAddr;
    int         lineBeats;         // Beats the port gives for a line
    logic       done;
    int         errors, checks;
    logic [15:0] cpuLfsr, portLfsr;

    clockGen clk_i (.BCLK(BCLK), .nRESET(nRESET));

    busSizer #(.BurstBeats(Beats)) busSizer_i (
        .BCLK(BCLK), .nRESET(nRESET), .nTS_CPU(nTS_CPU), .RnW(RnW), .SIZ(SIZ), .A(A),
        .TT(TT), .nTBI(nTBI), .nTA(nTA), .cpuDataIn(cpuDataIn), .cpuDataOut(cpuDataOut),
        .DSACK(DSACK), .nTS(nTS), .portSiz(portSiz), .portA(portA),
        .portDataIn(portDataIn), .portDataOut(portDataOut), .portDrive(portDrive)
    );

    busSizerCheck #(.BurstBeats(Beats)) check_i (
        .BCLK(BCLK), .nRESET(nRESET), .nTS_CPU(nTS_CPU), .RnW(RnW), .SIZ(SIZ), .nTBI(nTBI),
        .cpuDataIn(cpuDataIn), .cpuAddr(cpuAddr), .portWide(portWide), .done(done),
        .nTA(nTA), .nTS(nTS), .portSiz(portSiz), .portA(portA), .portDrive(portDrive),
        .cpuDataOut(cpuDataOut), .errors(errors), .checks(checks)
    );

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Maximal 16-bit taps
    endfunction

    task automatic randBits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsrStep(st);
            v  = {v[30:0], st[0]};                         // One step per bit
        end
    endtask

    //////////////////////////////
    // Port memory model
    //////////////////////////////

    function automatic busData readLanes(input logic [3:0] lw);
        logic [5:0] b;
        b = {lw, portA[1], 1'b0};
        if (portWide) return {portMem[{lw, 2'd0}], portMem[{lw, 2'd1}],
                              portMem[{lw, 2'd2}], portMem[{lw, 2'd3}]};
        return {portMem[b], portMem[b + 6'd1], 16'hEEEE};   // Narrow port uses lanes 0 and 1
    endfunction

    task automatic storeLanes(input logic [3:0] lw);
        int         n;
        logic [1:0] a;
        if (portWide) n = (portSiz == sizeByte) ? 1 : (portSiz == sizeWord) ? 2 : 4;
        else n = (portSiz == sizeByte) ? 1 : 2;
        for (int j = 0; j < n; j++) begin
            a = portA + 2'(j);
            portMem[{lw, a}] = portWide ? portDataOut[31 - 8*a -: 8]
                                        : portDataOut[31 - 8*a[0] -: 8];
        end
    endtask

    task automatic serveCycle();
        logic [3:0]  lw;
        logic [31:0] w;
        int          beat;
        int          last;
        lw   = cpuAddr[5:2];
        beat = 0;
        last = (portSiz == sizeLine && portWide) ? lineBeats : 1;
        while (beat < last) begin
            randBits(portLfsr, 2, w);
            repeat (w[1:0]) @(posedge BCLK);               // 0 to 3 wait cycles
            #1;
            DSACK      = portWide ? ack32 : ack16;
            portDataIn = readLanes(lw);
            @(posedge BCLK);
            if (portDrive) storeLanes(lw);
            #1;
            DSACK      = ackNone;
            portDataIn = 32'hEEEE_EEEE;
            lw++;
            beat++;
        end
    endtask

    initial begin
        DSACK      = ackNone;
        portDataIn = 32'hEEEE_EEEE;
        portLfsr   = 16'd58884;
        for (int a = 0; a < 64; a++) portMem[a] = 8'(a * 8'd29 + 8'h5A);
        forever begin
            @(posedge BCLK);
            if (nRESET && nTS === 1'b0) serveCycle();
        end
    end

    //////////////////////////////
    // CPU side
    //////////////////////////////

    task automatic runXfer(input logic wr, input xferSize siz, input logic [5:0] addr,
                           input logic tbi, input busData data);
        int got;
        int want;
        @(posedge BCLK);
        #1;
        want      = (siz == sizeLine && portWide && tbi) ? Beats : 1;
        lineBeats = tbi ? Beats : 1;
        cpuAddr   = addr;
        RnW       = !wr;
        SIZ       = siz;
        A         = addr[1:0];
        TT        = (siz == sizeLine) ? typeLine : 2'b00;
        nTBI      = tbi;
        cpuDataIn = data;
        nTS_CPU   = 1'b0;
        @(posedge BCLK);
        #1 nTS_CPU = 1'b1;
        got = 0;
        while (got < want) begin                          // Hold until the last nTA
            @(posedge BCLK);
            if (nTA === 1'b0) got++;
        end
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] d;
        logic [5:0]  ad;
        xferSize     sz;
        nTS_CPU   = 1'b1;
        RnW       = 1'b1;
        SIZ       = sizeLong;
        A         = 2'b00;
        TT        = 2'b00;
        nTBI      = 1'b1;
        cpuDataIn = '0;
        cpuAddr   = '0;
        portWide  = 1'b1;
        done      = 1'b0;
        lineBeats = Beats;
        cpuLfsr   = 16'd58884;
        @(posedge nRESET);
        repeat (4) @(posedge BCLK);                        // Idle outputs after reset

        runXfer(1, sizeLong, 6'd8, 1, 32'h1122_3344);      // Long on a 32-bit port
        runXfer(0, sizeLong, 6'd8, 1, '0);
        portWide = 1'b0;
        runXfer(1, sizeLong, 6'd12, 1, 32'h5566_7788);     // Split into two port cycles
        runXfer(0, sizeLong, 6'd12, 1, '0);
        for (int w = 0; w < 2; w++) begin
            portWide = w[0];
            for (int a = 0; a < 4; a += 2) begin
                runXfer(1, sizeWord, 6'(16 + a), 1, 32'hA1B2_C3D4 ^ w);
                runXfer(0, sizeWord, 6'(16 + a), 1, '0);
            end
            for (int a = 0; a < 4; a++) begin
                runXfer(1, sizeByte, 6'(20 + a), 1, 32'h0F1E_2D3C + a);
                runXfer(0, sizeByte, 6'(20 + a), 1, '0);
            end
        end
        portWide = 1'b1;
        runXfer(0, sizeLine, 6'd32, 1, '0);                // Full line
        runXfer(0, sizeLine, 6'd48, 0, '0);                // Burst inhibited
        portWide = 1'b0;
        runXfer(0, sizeLine, 6'd0, 1, '0);                 // Narrow answer ends after one long

        for (int n = 0; n < NumRandom; n++) begin
            randBits(cpuLfsr, 2, v);
            sz = xferSize'(v[1:0]);
            randBits(cpuLfsr, 6, v);
            ad = v[5:0];
            randBits(cpuLfsr, 32, d);
            randBits(cpuLfsr, 4, v);
            portWide = v[0];
            if (sz == sizeLine) ad = ad & 6'h30;
            if (sz == sizeLong) ad[1:0] = 2'b00;
            if (sz == sizeWord) ad[0] = 1'b0;
            runXfer(v[1] && sz != sizeLine, sz, ad, v[3:2] != 2'b00, d);
        end

        repeat (2) @(posedge BCLK);
        #1 done = 1'b1;
        repeat (2) @(posedge BCLK);
        $display("Transfers %0d, checks %0d, errors %0d", NumXfers, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog sized from the transfer count
    initial begin
        #(TimeoutNs);
        $display("Timeout: the transfers did not complete in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/clockGen.sv */
/* BCLK at 10 ns period. nRESET is held low for 8 cycles
   and released 1 ns after a rising edge. */
`default_nettype none

module clockGen (
    output logic BCLK,
    output logic nRESET
);
    timeunit 1ns;
    timeprecision 100ps;

    initial BCLK = 1'b0;
    always #5 BCLK = ~BCLK;          // 10 ns period

    initial begin
        nRESET = 1'b0;
        repeat (8) @(posedge BCLK);
        #1 nRESET = 1'b1;             // Released off the edge
    end

endmodule

`default_nettype wire
